// ==== bench/golden_frames.txt ====
# class len corrupt host_read pointer report
# class 0 best effort, 1 tte; len in bytes with fcs; pointer and report in hex
0 100 0 1 0060 00060
1 100 0 1 0060 08060
0 100 1 1 2060 10060
0 60 0 1 4038 20038
0 1530 0 1 a5ea 505ea
0 1518 0 0 05ea 005ea
0 1518 0 0 05ea 005ea
0 1518 0 0 dropped 80000
1 100 0 1 0060 08060

// ==== bench/mac_rx_tte_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_rx_tte_tb;

  localparam int MAX_FRAMES = 16;
  localparam int MAX_BYTES  = 2048;

  logic        rx_clk = 1'b0;
  logic        rstn_mac;
  logic        rx_dv;
  logic [7:0]  gm_rx_d;
  logic [1:0]  data_rd;
  logic [1:0]  ptr_rd;
  logic [7:0]  data_dout [2];
  logic [15:0] ptr_dout [2];
  logic [1:0]  ptr_empty;
  logic        rx_mgnt_valid;
  logic [19:0] rx_mgnt_data;
  logic        rx_mgnt_resp;

  // frame table from the golden file
  int          n_frames;
  int          f_class [MAX_FRAMES];
  int          f_len [MAX_FRAMES];
  int          f_bad [MAX_FRAMES];
  int          f_read [MAX_FRAMES];
  bit          f_drop [MAX_FRAMES];
  logic [15:0] f_ptr [MAX_FRAMES];
  logic [19:0] f_rep [MAX_FRAMES];
  logic [7:0]  frame_mem [MAX_FRAMES][MAX_BYTES];

  int          lane_frames [2][$];   // admitted frames not yet read, per lane
  logic [19:0] exp_reports [$];
  bit          drain;
  int          value_errors;
  int          other_errors;
  int          limit_cycles;
  logic [31:0] rng_state = 32'd15780;

  always #20 rx_clk = ~rx_clk;

  mac_rx_tte_top mac_rx_tte_top_i (
    .rx_clk            (rx_clk),
    .rstn_mac          (rstn_mac),
    .rx_dv             (rx_dv),
    .gm_rx_d           (gm_rx_d),
    .data_fifo_rd      (data_rd[0]),
    .data_fifo_dout    (data_dout[0]),
    .ptr_fifo_rd       (ptr_rd[0]),
    .ptr_fifo_dout     (ptr_dout[0]),
    .ptr_fifo_empty    (ptr_empty[0]),
    .tte_fifo_rd       (data_rd[1]),
    .tte_fifo_dout     (data_dout[1]),
    .tteptr_fifo_rd    (ptr_rd[1]),
    .tteptr_fifo_dout  (ptr_dout[1]),
    .tteptr_fifo_empty (ptr_empty[1]),
    .rx_mgnt_valid     (rx_mgnt_valid),
    .rx_mgnt_data      (rx_mgnt_data),
    .rx_mgnt_resp      (rx_mgnt_resp)
  );

  // ====================================================================
  // frame generation
  // ====================================================================
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // reflected 802.3 polynomial, lsb first
  function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] b);
    logic [31:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      c = (c[0] ^ b[i]) ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
    end
    return c;
  endfunction

  task automatic build_frame(input int f);
    logic [31:0] crc;
    logic [31:0] fcs;
    int          body;
    body = f_len[f] - 4;
    crc  = 32'hFFFFFFFF;
    for (int i = 0; i < body; i++) begin
      rng_state = xorshift32(rng_state);
      frame_mem[f][i] = rng_state[7:0];
      if (i == 12) frame_mem[f][i] = 8'h08;
      if (i == 13) frame_mem[f][i] = (f_class[f] == 1) ? 8'h92 : 8'h00;  // type low byte
      crc = crc_step(crc, frame_mem[f][i]);
    end
    fcs = ~crc;
    if (f_bad[f] != 0) fcs = ~fcs;
    for (int k = 0; k < 4; k++) begin
      frame_mem[f][body+k] = fcs[8*k +: 8];
    end
  endtask

  task automatic load_golden();
    int    fd;
    int    got;
    string line;
    string ptr_s;
    n_frames = 0;
    fd = $fopen("bench/golden_frames.txt", "r");
    assert (fd != 0) else begin
      other_errors++;
      $display("golden file bench/golden_frames.txt could not be opened");
    end
    if (fd != 0) begin
      while (!$feof(fd) && n_frames < MAX_FRAMES) begin
        got = $fgets(line, fd);
        if (got > 0 && line.len() > 0 && line[0] != 8'h23) begin
          got = $sscanf(line, "%d %d %d %d %s %h", f_class[n_frames], f_len[n_frames],
                        f_bad[n_frames], f_read[n_frames], ptr_s, f_rep[n_frames]);
          if (got == 6) begin
            f_drop[n_frames] = (ptr_s == "dropped");
            f_ptr[n_frames]  = '0;
            if (!f_drop[n_frames]) got = $sscanf(ptr_s, "%h", f_ptr[n_frames]);
            n_frames++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic send_frame(input int f);
    int n;
    n = (f_len[f] < MAX_BYTES) ? f_len[f] : MAX_BYTES;
    for (int i = 0; i < 8; i++) begin
      @(posedge rx_clk);
      rx_dv   <= 1'b1;
      gm_rx_d <= (i == 7) ? 8'hD5 : 8'h55;   // preamble then sfd
    end
    for (int i = 0; i < n; i++) begin
      @(posedge rx_clk);
      gm_rx_d <= frame_mem[f][i];
    end
    @(posedge rx_clk);
    rx_dv   <= 1'b0;
    gm_rx_d <= 8'h00;
    repeat (11) @(posedge rx_clk);
  endtask

  // ====================================================================
  // host side
  // ====================================================================
  task automatic service_lane(input int ln);
    int f;
    int nbytes;
    forever begin
      @(negedge rx_clk);
      if (!ptr_empty[ln]) begin
        if (lane_frames[ln].size() == 0) begin
          assert (0) else begin
            other_errors++;
            $display("lane %0d holds a pointer that no frame should have produced", ln);
          end
          @(posedge rx_clk) ptr_rd[ln] <= 1'b1;
          @(posedge rx_clk) ptr_rd[ln] <= 1'b0;
        end else if (f_read[lane_frames[ln][0]] != 0 || drain) begin
          f = lane_frames[ln][0];
          assert (ptr_dout[ln] == f_ptr[f]) else begin
            value_errors++;
            $display("FAIL ptr_dout[%0d] frame %0d got %h expected %h",
                     ln, f, ptr_dout[ln], f_ptr[f]);
          end
          @(posedge rx_clk) ptr_rd[ln] <= 1'b1;
          @(posedge rx_clk);
          ptr_rd[ln]  <= 1'b0;
          data_rd[ln] <= 1'b1;
          nbytes = int'(f_ptr[f][12:0]) + 4;     // queue keeps the fcs
          for (int i = 0; i < nbytes; i++) begin
            @(negedge rx_clk);
            assert (data_dout[ln] == frame_mem[f][i]) else begin
              value_errors++;
              $display("FAIL data_dout[%0d] frame %0d byte %0d got %h expected %h",
                       ln, f, i, data_dout[ln], frame_mem[f][i]);
            end
            @(posedge rx_clk);
          end
          data_rd[ln] <= 1'b0;
          void'(lane_frames[ln].pop_front());
        end
      end
    end
  endtask

  task automatic answer_reports();
    logic [19:0] held;
    forever begin
      @(negedge rx_clk);
      if (rx_mgnt_valid) begin
        held = rx_mgnt_data;
        if (exp_reports.size() == 0) begin
          assert (0) else begin
            other_errors++;
            $display("a management report came without a frame to match it");
          end
        end else begin
          assert (held == exp_reports[0]) else begin
            value_errors++;
            $display("FAIL rx_mgnt_data got %h expected %h", held, exp_reports[0]);
          end
          void'(exp_reports.pop_front());
        end
        repeat (2) begin
          @(negedge rx_clk);
          assert (rx_mgnt_valid && rx_mgnt_data == held) else begin
            other_errors++;
            $display("report changed or was withdrawn before the response");
          end
        end
        @(posedge rx_clk) rx_mgnt_resp <= 1'b1;
        @(posedge rx_clk) rx_mgnt_resp <= 1'b0;
        @(negedge rx_clk);
        assert (!rx_mgnt_valid) else begin
          other_errors++;
          $display("rx_mgnt_valid stayed high after the response");
        end
      end
    end
  endtask

  task automatic watchdog();
    repeat (limit_cycles) @(posedge rx_clk);
    $display("watchdog expired after %0d cycles, the run did not finish", limit_cycles);
    $display("errors: %0d value, %0d other", value_errors, other_errors);
    $display("Something failed");
    $finish;
  endtask

  // ====================================================================
  // main sequence
  // ====================================================================
  initial begin
    rstn_mac     = 1'b0;
    rx_dv        = 1'b0;
    gm_rx_d      = 8'h00;
    data_rd      = 2'b00;
    ptr_rd       = 2'b00;
    rx_mgnt_resp = 1'b0;
    drain        = 1'b0;
    value_errors = 0;
    other_errors = 0;

    load_golden();
    limit_cycles = 0;
    for (int f = 0; f < n_frames; f++) begin
      build_frame(f);
      limit_cycles += f_len[f] + 40;
    end
    limit_cycles *= 2;
    fork
      watchdog();
    join_none

    repeat (3) @(posedge rx_clk);
    @(negedge rx_clk);
    assert (ptr_empty == 2'b11 && !rx_mgnt_valid) else begin
      other_errors++;
      $display("queues not empty or report valid during reset");
    end
    @(posedge rx_clk) rstn_mac <= 1'b1;
    @(negedge rx_clk);
    assert (ptr_empty == 2'b11 && !rx_mgnt_valid) else begin
      other_errors++;
      $display("queues not empty or report valid after reset");
    end

    fork
      service_lane(0);
      service_lane(1);
      answer_reports();
    join_none

    for (int f = 0; f < n_frames; f++) begin
      if (!f_drop[f]) lane_frames[f_class[f]].push_back(f);
      exp_reports.push_back(f_rep[f]);
      send_frame(f);
    end

    drain = 1'b1;    // host now reads the held frames too
    while (lane_frames[0].size() > 0 || lane_frames[1].size() > 0 ||
           exp_reports.size() > 0) begin
      @(posedge rx_clk);
    end
    repeat (20) @(posedge rx_clk);
    @(negedge rx_clk);
    assert (ptr_empty == 2'b11 && !rx_mgnt_valid) else begin
      other_errors++;
      $display("pointer queues hold extra entries at the end of the run");
    end

    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/crc32_8023.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc32_8023 (
  input  logic              rx_clk,
  input  logic              rstn_mac,
  input  logic              crc_init,
  input  logic              crc_en,
  input  mac_rx_pkg::byte_t crc_byte,
  output logic              crc_good
);

  import mac_rx_pkg::*;

  localparam logic [31:0] POLY_REFL = 32'hEDB88320;  // 0x04C11DB7 bit reversed

  logic [31:0] crc_q;
  logic [31:0] crc_next;
  logic [31:0] crc_rev;

  // lsb first, one bit per step
  always_comb begin
    crc_next = crc_q;
    for (int i = 0; i < 8; i++) begin
      if (crc_next[0] ^ crc_byte[i]) begin
        crc_next = (crc_next >> 1) ^ POLY_REFL;
      end else begin
        crc_next = crc_next >> 1;
      end
    end
  end

  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      crc_q <= '1;
    end else if (crc_init) begin
      crc_q <= '1;
    end else if (crc_en) begin
      crc_q <= crc_next;
    end
  end

  // residue is given msb first, the register runs reflected
  assign crc_rev  = {<<{crc_q}};
  assign crc_good = (crc_rev == CRC_RESIDUE);

endmodule

`default_nettype wire

// ==== logic/gmii_rx_front.sv ====
`timescale 1ns/1ps
`default_nettype none

module gmii_rx_front #(
  parameter int MTU = 1500
) (
  input  logic              rx_clk,
  input  logic              rstn_mac,
  input  logic              rx_dv,
  input  mac_rx_pkg::byte_t gm_rx_d,
  output mac_rx_pkg::byte_t frm_byte,
  output logic              frm_valid,
  output logic              frm_sof,
  output logic              frm_tte,
  output logic              frm_eof,
  output logic              frm_crc_err,
  output logic              frm_giant,
  output mac_rx_pkg::len_t  frm_len
);

  import mac_rx_pkg::*;

  localparam len_t MAX_LEN = len_t'(MTU + 18);

  typedef enum logic [1:0] {HUNT, FRAME, SKIP} in_state_t;

  in_state_t            in_state;
  logic                 dv_q;
  byte_t                d_q;
  len_t                 byte_cnt;
  logic                 sfd_hit;
  logic                 byte_ok;
  logic                 frame_end;
  logic                 crc_good;
  byte_t                dly [HDR_DELAY];
  logic [HDR_DELAY-1:0] dly_v;
  logic                 out_on;

  // ===================================================================
  // input register and sfd search
  // ===================================================================
  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      dv_q <= 1'b0;
    end else begin
      dv_q <= rx_dv;
    end
  end

  always_ff @(posedge rx_clk) begin
    d_q <= gm_rx_d;
  end

  assign sfd_hit   = (in_state == HUNT) && dv_q && (d_q == SFD_BYTE);
  assign byte_ok   = (in_state == FRAME) && dv_q && (byte_cnt != MAX_LEN);
  assign frame_end = (in_state == FRAME) && (!dv_q || byte_cnt == MAX_LEN);

  // byte_cnt is the index of the byte in d_q
  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      in_state <= HUNT;
      byte_cnt <= '0;
    end else begin
      case (in_state)
        HUNT: begin
          if (sfd_hit) begin
            in_state <= FRAME;
            byte_cnt <= '0;
          end
        end
        FRAME: begin
          if (!dv_q) begin
            in_state <= HUNT;
          end else if (byte_cnt == MAX_LEN) begin
            in_state <= SKIP;          // truncate, drop the rest
          end else begin
            byte_cnt <= byte_cnt + 1'b1;
          end
        end
        default: begin
          if (!dv_q) begin
            in_state <= HUNT;
          end
        end
      endcase
    end
  end

  crc32_8023 crc32_8023_i (
    .rx_clk   (rx_clk),
    .rstn_mac (rstn_mac),
    .crc_init (sfd_hit),
    .crc_en   (byte_ok),
    .crc_byte (d_q),
    .crc_good (crc_good)
  );

  // ===================================================================
  // class decision and end of frame status
  // ===================================================================
  // byte 0 reaches the delay line output one cycle after byte 13 is seen
  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      frm_sof <= 1'b0;
      frm_tte <= 1'b0;
    end else begin
      frm_sof <= byte_ok && (byte_cnt == len_t'(TYPE_BYTE_INDEX));
      if (byte_ok && byte_cnt == len_t'(TYPE_BYTE_INDEX)) begin
        frm_tte <= (d_q == TTE_TYPE_BYTE);
      end
    end
  end

  // latched only for frames that got past the type byte
  always_ff @(posedge rx_clk) begin
    if (frame_end && byte_cnt > len_t'(TYPE_BYTE_INDEX)) begin
      frm_len     <= byte_cnt;
      frm_giant   <= dv_q;        // still receiving means truncated
      frm_crc_err <= !crc_good;
    end
  end

  // ===================================================================
  // delay line
  // ===================================================================
  always_ff @(posedge rx_clk) begin
    dly[0] <= d_q;
    for (int i = 1; i < HDR_DELAY; i++) begin
      dly[i] <= dly[i-1];
    end
  end

  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      dly_v  <= '0;
      out_on <= 1'b0;
    end else begin
      dly_v <= {dly_v[HDR_DELAY-2:0], byte_ok};
      if (frm_sof) begin
        out_on <= 1'b1;
      end else if (!dly_v[HDR_DELAY-1]) begin
        out_on <= 1'b0;
      end
    end
  end

  // short frames never see sof, their bytes fall off the end
  assign frm_byte  = dly[HDR_DELAY-1];
  assign frm_valid = dly_v[HDR_DELAY-1] && (frm_sof || out_on);
  assign frm_eof   = out_on && !dly_v[HDR_DELAY-1];

endmodule

`default_nettype wire

// ==== logic/mac_rx_pkg.sv ====
`default_nettype none

package mac_rx_pkg;

  // ===================================================================
  // data types
  // ===================================================================
  typedef logic [7:0]  byte_t;
  typedef logic [12:0] len_t;

  // pointer word, one per queued frame
  typedef struct packed {
    logic giant;
    logic runt;
    logic crc_err;
    len_t len;        // frame length without fcs
  } rx_ptr_t;

  // management report to the host
  typedef struct packed {
    logic        dropped;
    logic [2:0]  err;   // giant, runt, crc in pointer order
    logic        tte;
    logic [2:0]  rsvd;
    logic [11:0] len;
  } rx_mgnt_t;

  // ===================================================================
  // frame constants
  // ===================================================================
  localparam byte_t       SFD_BYTE        = 8'hD5;
  localparam byte_t       TTE_TYPE_BYTE   = 8'h92;  // low byte of the tte ethertype
  localparam int          TYPE_BYTE_INDEX = 13;
  localparam int          HDR_DELAY       = 14;     // delay line depth
  localparam logic [31:0] CRC_RESIDUE     = 32'hC704DD7B;
  localparam int          FCS_BYTES       = 4;
  localparam int          MIN_FRAME       = 64;
  localparam int          LANE_COUNT      = 2;      // lane 0 best effort, lane 1 tte

endpackage

`default_nettype wire

// ==== logic/mac_rx_tte_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_rx_tte_top #(
  parameter int MTU        = 1500,
  parameter int DATA_DEPTH = 4096,
  parameter int PTR_DEPTH  = 32
) (
  input  logic                 rx_clk,
  input  logic                 rstn_mac,
  input  logic                 rx_dv,
  input  mac_rx_pkg::byte_t    gm_rx_d,
  input  logic                 data_fifo_rd,
  output mac_rx_pkg::byte_t    data_fifo_dout,
  input  logic                 ptr_fifo_rd,
  output mac_rx_pkg::rx_ptr_t  ptr_fifo_dout,
  output logic                 ptr_fifo_empty,
  input  logic                 tte_fifo_rd,
  output mac_rx_pkg::byte_t    tte_fifo_dout,
  input  logic                 tteptr_fifo_rd,
  output mac_rx_pkg::rx_ptr_t  tteptr_fifo_dout,
  output logic                 tteptr_fifo_empty,
  output logic                 rx_mgnt_valid,
  output mac_rx_pkg::rx_mgnt_t rx_mgnt_data,
  input  logic                 rx_mgnt_resp
);

  import mac_rx_pkg::*;

  byte_t                     frm_byte;
  logic                      frm_valid;
  logic                      frm_sof;
  logic                      frm_tte;
  logic                      frm_eof;
  logic                      frm_crc_err;
  logic                      frm_giant;
  len_t                      frm_len;
  logic [LANE_COUNT-1:0]     data_rd;
  logic [LANE_COUNT-1:0]     ptr_rd;
  logic [LANE_COUNT-1:0]     ptr_empty;
  logic [LANE_COUNT-1:0]     lane_accept;
  logic [LANE_COUNT-1:0]     lane_drop;
  logic [LANE_COUNT-1:0]     lane_ptr_wr;
  byte_t   [LANE_COUNT-1:0]  data_dout;
  rx_ptr_t [LANE_COUNT-1:0]  ptr_dout;
  rx_ptr_t [LANE_COUNT-1:0]  lane_ptr;

  gmii_rx_front #(.MTU(MTU)) gmii_rx_front_i (
    .rx_clk      (rx_clk),
    .rstn_mac    (rstn_mac),
    .rx_dv       (rx_dv),
    .gm_rx_d     (gm_rx_d),
    .frm_byte    (frm_byte),
    .frm_valid   (frm_valid),
    .frm_sof     (frm_sof),
    .frm_tte     (frm_tte),
    .frm_eof     (frm_eof),
    .frm_crc_err (frm_crc_err),
    .frm_giant   (frm_giant),
    .frm_len     (frm_len)
  );

  // lane 0 best effort, lane 1 tte
  assign data_rd           = {tte_fifo_rd, data_fifo_rd};
  assign ptr_rd            = {tteptr_fifo_rd, ptr_fifo_rd};
  assign data_fifo_dout    = data_dout[0];
  assign tte_fifo_dout     = data_dout[1];
  assign ptr_fifo_dout     = ptr_dout[0];
  assign tteptr_fifo_dout  = ptr_dout[1];
  assign ptr_fifo_empty    = ptr_empty[0];
  assign tteptr_fifo_empty = ptr_empty[1];

  for (genvar g = 0; g < LANE_COUNT; g++) begin : g_lane
    rx_queue_lane #(
      .LANE_TTE   (1'(g)),
      .MTU        (MTU),
      .DATA_DEPTH (DATA_DEPTH),
      .PTR_DEPTH  (PTR_DEPTH)
    ) rx_queue_lane_i (
      .rx_clk      (rx_clk),
      .rstn_mac    (rstn_mac),
      .frm_byte    (frm_byte),
      .frm_valid   (frm_valid),
      .frm_sof     (frm_sof),
      .frm_tte     (frm_tte),
      .frm_eof     (frm_eof),
      .frm_len     (frm_len),
      .frm_crc_err (frm_crc_err),
      .frm_giant   (frm_giant),
      .data_rd     (data_rd[g]),
      .data_dout   (data_dout[g]),
      .ptr_rd      (ptr_rd[g]),
      .ptr_dout    (ptr_dout[g]),
      .ptr_empty   (ptr_empty[g]),
      .lane_accept (lane_accept[g]),
      .lane_drop   (lane_drop[g]),
      .lane_ptr_wr (lane_ptr_wr[g]),
      .lane_ptr    (lane_ptr[g])
    );
  end

  rx_mgnt_report rx_mgnt_report_i (
    .rx_clk        (rx_clk),
    .rstn_mac      (rstn_mac),
    .lane_accept   (lane_accept),
    .lane_drop     (lane_drop),
    .lane_ptr_wr   (lane_ptr_wr),
    .lane_ptr      (lane_ptr),
    .rx_mgnt_resp  (rx_mgnt_resp),
    .rx_mgnt_valid (rx_mgnt_valid),
    .rx_mgnt_data  (rx_mgnt_data)
  );

endmodule

`default_nettype wire

// ==== logic/rx_mgnt_report.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_mgnt_report (
  input  logic                                          rx_clk,
  input  logic                                          rstn_mac,
  input  logic [mac_rx_pkg::LANE_COUNT-1:0]             lane_accept,
  input  logic [mac_rx_pkg::LANE_COUNT-1:0]             lane_drop,
  input  logic [mac_rx_pkg::LANE_COUNT-1:0]             lane_ptr_wr,
  input  mac_rx_pkg::rx_ptr_t [mac_rx_pkg::LANE_COUNT-1:0] lane_ptr,
  input  logic                                          rx_mgnt_resp,
  output logic                                          rx_mgnt_valid,
  output mac_rx_pkg::rx_mgnt_t                          rx_mgnt_data
);

  import mac_rx_pkg::*;

  localparam int LW = (LANE_COUNT > 1) ? $clog2(LANE_COUNT) : 1;

  typedef enum logic [1:0] {IDLE, WAIT_PTR, HOLD} rep_state_t;

  rep_state_t state;
  logic [LW-1:0] acc_lane;
  logic [LW-1:0] drop_lane;
  logic [LW-1:0] lane_q;
  rx_mgnt_t      rep_q;

  // at most one lane reacts to a frame start
  always_comb begin
    acc_lane  = '0;
    drop_lane = '0;
    for (int i = 0; i < LANE_COUNT; i++) begin
      if (lane_accept[i]) acc_lane = LW'(i);
      if (lane_drop[i]) drop_lane = LW'(i);
    end
  end

  // ===================================================================
  // report FSM
  // ===================================================================
  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      state  <= IDLE;
      lane_q <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (|lane_accept) begin
            state  <= WAIT_PTR;
            lane_q <= acc_lane;
          end else if (|lane_drop) begin
            state <= HOLD;
          end
        end
        WAIT_PTR: if (lane_ptr_wr[lane_q]) state <= HOLD;
        HOLD:     if (rx_mgnt_resp) state <= IDLE;
        default:  state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge rx_clk) begin
    if (state == IDLE) begin
      if (|lane_accept) begin
        rep_q     <= '0;
        rep_q.tte <= (acc_lane == LW'(1));   // lane 1 carries tte
      end else if (|lane_drop) begin
        rep_q         <= '0;
        rep_q.dropped <= 1'b1;
        rep_q.tte     <= (drop_lane == LW'(1));
      end
    end else if (state == WAIT_PTR && lane_ptr_wr[lane_q]) begin
      rep_q.err <= {lane_ptr[lane_q].giant, lane_ptr[lane_q].runt, lane_ptr[lane_q].crc_err};
      rep_q.len <= lane_ptr[lane_q].len[11:0];
    end
  end

  assign rx_mgnt_valid = (state == HOLD);
  assign rx_mgnt_data  = rep_q;

endmodule

`default_nettype wire

// ==== logic/rx_queue_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_queue_lane #(
  parameter bit LANE_TTE   = 1'b0,
  parameter int MTU        = 1500,
  parameter int DATA_DEPTH = 4096,
  parameter int PTR_DEPTH  = 32
) (
  input  logic                rx_clk,
  input  logic                rstn_mac,
  input  mac_rx_pkg::byte_t   frm_byte,
  input  logic                frm_valid,
  input  logic                frm_sof,
  input  logic                frm_tte,
  input  logic                frm_eof,
  input  mac_rx_pkg::len_t    frm_len,
  input  logic                frm_crc_err,
  input  logic                frm_giant,
  input  logic                data_rd,
  output mac_rx_pkg::byte_t   data_dout,
  input  logic                ptr_rd,
  output mac_rx_pkg::rx_ptr_t ptr_dout,
  output logic                ptr_empty,
  output logic                lane_accept,
  output logic                lane_drop,
  output logic                lane_ptr_wr,
  output mac_rx_pkg::rx_ptr_t lane_ptr
);

  import mac_rx_pkg::*;

  localparam int DFREE_W = $clog2(DATA_DEPTH + 1);

  logic               mine;
  logic               room;
  logic               active;
  logic               data_wr;
  byte_t              data_din;
  logic [DFREE_W-1:0] data_free;
  logic               ptr_full;
  logic               ptr_wr;
  rx_ptr_t            ptr_q;

  // ===================================================================
  // admission
  // ===================================================================
  assign mine = (frm_tte == LANE_TTE);
  assign room = (data_free >= DFREE_W'(MTU + 18)) && !ptr_full;  // worst case frame fits

  assign lane_accept = frm_sof && mine && room;
  assign lane_drop   = frm_sof && mine && !room;

  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      active  <= 1'b0;
      data_wr <= 1'b0;
      ptr_wr  <= 1'b0;
    end else begin
      if (lane_accept) begin
        active <= 1'b1;
      end else if (frm_eof) begin
        active <= 1'b0;
      end
      data_wr <= frm_valid && (lane_accept || active);
      ptr_wr  <= frm_eof && active;
    end
  end

  // ===================================================================
  // pointer word
  // ===================================================================
  always_ff @(posedge rx_clk) begin
    data_din <= frm_byte;
    if (frm_eof) begin
      ptr_q.len     <= frm_len - len_t'(FCS_BYTES);
      ptr_q.crc_err <= frm_crc_err;
      ptr_q.runt    <= (frm_len < len_t'(MIN_FRAME));
      ptr_q.giant   <= frm_giant;
    end
  end

  assign lane_ptr_wr = ptr_wr;
  assign lane_ptr    = ptr_q;

  // data queue keeps the fcs bytes
  sync_fifo #(
    .payload_t (byte_t),
    .DEPTH     (DATA_DEPTH)
  ) data_fifo_i (
    .rx_clk   (rx_clk),
    .rstn_mac (rstn_mac),
    .wr       (data_wr),
    .din      (data_din),
    .rd       (data_rd),
    .dout     (data_dout),
    .empty    (),
    .full     (),
    .free     (data_free)
  );

  sync_fifo #(
    .payload_t (rx_ptr_t),
    .DEPTH     (PTR_DEPTH)
  ) ptr_fifo_i (
    .rx_clk   (rx_clk),
    .rstn_mac (rstn_mac),
    .wr       (ptr_wr),
    .din      (ptr_q),
    .rd       (ptr_rd),
    .dout     (ptr_dout),
    .empty    (ptr_empty),
    .full     (ptr_full),
    .free     ()
  );

endmodule

`default_nettype wire

// ==== logic/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 16
) (
  input  logic                       rx_clk,
  input  logic                       rstn_mac,
  input  logic                       wr,
  input  payload_t                   din,
  input  logic                       rd,
  output payload_t                   dout,
  output logic                       empty,
  output logic                       full,
  output logic [$clog2(DEPTH+1)-1:0] free
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          push;
  logic          pop;

  assign push = wr && !full;    // writes to a full queue are lost
  assign pop  = rd && !empty;

  always_ff @(posedge rx_clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign dout  = mem[rd_ptr];   // fall through, head is always visible
  assign empty = (count == '0);
  assign full  = (count == CW'(DEPTH));
  assign free  = CW'(DEPTH) - count;

endmodule

`default_nettype wire

// ==== mac_rx_tte.f ====
logic/mac_rx_pkg.sv
logic/crc32_8023.sv
logic/gmii_rx_front.sv
logic/sync_fifo.sv
logic/rx_queue_lane.sv
logic/rx_mgnt_report.sv
logic/mac_rx_tte_top.sv
bench/mac_rx_tte_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the receive MAC testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f mac_rx_tte.f --top-module mac_rx_tte_tb \
  -o mac_rx_tte_sim && ./obj_dir/mac_rx_tte_sim > sim.log 2>&1 || {
  echo "build or simulation failed, see sim.log"
  exit 1
}

grep -q "^Everything OK$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
